// ==== common/cpu_mem_pkg.sv ====
// cpu memory subsystem shared definitions
// word and address types, host opcodes, loader states, boot block table
package cpu_mem_pkg;

    typedef logic [31:0]  word_t;       // data or instruction word
    typedef logic [15:0]  addr_t;       // local byte address
    typedef logic [63:0]  host_addr_t;
    typedef logic [511:0] line_t;       // 16 words, lowest address in [31:0]

    typedef enum logic [1:0] {
        HOST_IDLE  = 2'b00,
        HOST_READ  = 2'b01,
        HOST_WRITE = 2'b11
    } host_op_t;

    typedef enum logic [2:0] {
        LD_IDLE,
        WAIT_INIT_DM,
        INIT_DM,
        WAIT_INIT_IM,
        INIT_IM,
        RUN,
        WRT_HOST
    } loader_state_t;

    ////////////////////////////////////////////////////////////
    // boot transfer geometry

    localparam int unsigned WORDS_PER_BLOCK = 16;
    localparam addr_t       BLOCK_BYTES     = 16'h0040;

    localparam int unsigned DM_BLOCKS = 17;

    // data block bases in host request order
    localparam addr_t DM_BLOCK_BASE [0:DM_BLOCKS-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

    localparam int unsigned IM_HOST_FLAG_BIT = 16;   // marks instruction blocks

    // stores at or above this go to the host
    localparam addr_t HOST_BASE = 16'h9000;

endpackage

// ==== host_loader/host_loader.sv ====
// boot loader and host port
// copies data then instruction blocks from the host, forwards host-window stores
module host_loader import cpu_mem_pkg::*; #(
    parameter int unsigned IM_BLOCKS = 48
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       host_ready,
    input  logic       host_rd_valid,
    input  logic       host_tx_done,
    input  word_t      host_rd_data,
    input  addr_t      cpu_addr,
    input  logic       cpu_wrt_en,
    input  word_t      cpu_wrt_data,
    output host_op_t   host_op,
    output host_addr_t host_addr,
    output word_t      host_wrt_data,
    output logic       cpu_stall,
    output logic       host_claim,
    output logic       ld_wrt_en,
    output addr_t      ld_addr,
    output word_t      ld_wrt_data,
    output logic       im_wrt_en,
    output addr_t      im_wrt_addr,
    output word_t      im_wrt_data
);

    localparam int unsigned DM_CNT_W = $clog2(DM_BLOCKS);
    localparam int unsigned IM_CNT_W = (IM_BLOCKS > 1) ? $clog2(IM_BLOCKS) : 1;
    localparam host_addr_t  IM_FLAG  = host_addr_t'(1) << IM_HOST_FLAG_BIT;

    loader_state_t       state, next_state;
    logic [DM_CNT_W-1:0] dm_count;
    logic [IM_CNT_W-1:0] im_count;
    logic                dm_last, im_last;
    addr_t               dm_base, im_base;
    addr_t               run_addr;      // next word inside the current block

    assign dm_base = DM_BLOCK_BASE[dm_count];
    assign im_base = addr_t'(im_count) * BLOCK_BYTES;
    assign dm_last = (dm_count == DM_CNT_W'(DM_BLOCKS - 1));
    assign im_last = (im_count == IM_CNT_W'(IM_BLOCKS - 1));

    // the one host window compare
    assign host_claim = cpu_wrt_en && (cpu_addr >= HOST_BASE);

    assign ld_wrt_data = host_rd_data;
    assign im_wrt_data = host_rd_data;

    ////////////////////////////////////////////////////////////
    // state, block counters, running address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dm_count <= '0;
            im_count <= '0;
        end else begin
            if (state == INIT_DM && host_tx_done && !dm_last) begin
                dm_count <= dm_count + 1'b1;
            end
            if (state == INIT_IM && host_tx_done && !im_last) begin
                im_count <= im_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_addr <= '0;
        end else if (state == WAIT_INIT_DM && host_rd_valid) begin
            run_addr <= dm_base + 16'd4;         // first word went to the base
        end else if (state == WAIT_INIT_IM && host_rd_valid) begin
            run_addr <= im_base + 16'd4;
        end else if (state == INIT_DM || state == INIT_IM) begin
            run_addr <= run_addr + 16'd4;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and host / memory outputs

    always_comb begin
        next_state    = state;
        host_op       = HOST_IDLE;
        host_addr     = '0;
        host_wrt_data = '0;
        cpu_stall     = 1'b1;                    // held off until boot is over
        ld_wrt_en     = 1'b0;
        ld_addr       = dm_base;
        im_wrt_en     = 1'b0;
        im_wrt_addr   = im_base;

        case (state)
            LD_IDLE: begin
                if (host_ready) begin
                    next_state = WAIT_INIT_DM;
                end
            end
            WAIT_INIT_DM: begin
                host_op   = HOST_READ;
                host_addr = host_addr_t'(dm_base);
                if (host_rd_valid) begin
                    ld_wrt_en  = 1'b1;
                    next_state = INIT_DM;
                end
            end
            INIT_DM: begin
                host_op   = HOST_READ;
                host_addr = host_addr_t'(dm_base);
                ld_wrt_en = 1'b1;
                ld_addr   = run_addr;
                if (host_tx_done) begin
                    next_state = dm_last ? WAIT_INIT_IM : WAIT_INIT_DM;
                end
            end
            WAIT_INIT_IM: begin
                host_op   = HOST_READ;
                host_addr = host_addr_t'(im_base) | IM_FLAG;
                if (host_rd_valid) begin
                    im_wrt_en  = 1'b1;
                    next_state = INIT_IM;
                end
            end
            INIT_IM: begin
                host_op     = HOST_READ;
                host_addr   = host_addr_t'(im_base) | IM_FLAG;
                im_wrt_en   = 1'b1;
                im_wrt_addr = run_addr;
                if (host_tx_done) begin
                    next_state = im_last ? RUN : WAIT_INIT_IM;
                end
            end
            RUN: begin
                cpu_stall = host_claim;          // hold the store until the host takes it
                if (host_claim) begin
                    host_op       = HOST_WRITE;
                    host_addr     = host_addr_t'(cpu_addr);
                    host_wrt_data = cpu_wrt_data;
                    next_state    = WRT_HOST;
                end
            end
            WRT_HOST: begin
                host_op       = HOST_WRITE;
                host_addr     = host_addr_t'(cpu_addr);
                host_wrt_data = cpu_wrt_data;
                cpu_stall     = !host_tx_done;   // released in the done cycle
                if (host_tx_done) begin
                    next_state = RUN;
                end
            end
            default: begin
                next_state = LD_IDLE;
            end
        endcase
    end

    // host must not finish a transfer nobody asked for
    a_no_done_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == LD_IDLE) |-> !host_tx_done);

    // block counters only step in INIT, a done before the first word is lost
    a_no_done_before_data: assert property (@(posedge clk) disable iff (!rst_n)
        (state == WAIT_INIT_DM || state == WAIT_INIT_IM) |-> !host_tx_done);

endmodule

// ==== memory/data_mem.sv ====
// shared data memory
// lines of 16 words, word write, registered word read and full line read
module data_mem import cpu_mem_pkg::*; #(
    parameter int unsigned DM_LINES = 512
) (
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t mem_addr,
    input  logic  mem_wrt_en,
    input  word_t mem_wrt_data,
    input  logic  mem_rd_en,
    input  logic  mem_line_rd_en,
    output word_t mem_rd_data,
    output line_t mem_line_data
);

    localparam int unsigned LINE_AW = (DM_LINES > 1) ? $clog2(DM_LINES) : 1;

    line_t              mem [DM_LINES];
    logic [LINE_AW-1:0] line_idx;
    logic [3:0]         word_idx;       // word inside the line
    line_t              cur_line;

    // byte address -> line / word
    assign line_idx = mem_addr[LINE_AW+5:6];
    assign word_idx = mem_addr[5:2];
    assign cur_line = mem[line_idx];

    always_ff @(posedge clk) begin
        if (mem_wrt_en) begin
            mem[line_idx][32*word_idx +: 32] <= mem_wrt_data;
        end
    end

    // one cycle read latency on both outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rd_data   <= '0;
            mem_line_data <= '0;
        end else begin
            if (mem_rd_en) begin
                mem_rd_data <= cur_line[32*word_idx +: 32];
            end
            if (mem_line_rd_en) begin
                mem_line_data <= cur_line;  // aligned line, lowest word in [31:0]
            end
        end
    end

endmodule

// ==== memory/mem_arbiter.sv ====
// data memory arbiter
// fixed priority loader > cpu > accelerator, accelerator done/valid pulses
module mem_arbiter import cpu_mem_pkg::*; #(
    parameter int unsigned DM_LINES = 512
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ld_wrt_en,
    input  addr_t ld_addr,
    input  word_t ld_wrt_data,
    input  logic  host_claim,
    input  addr_t cpu_addr,
    input  logic  cpu_wrt_en,
    input  logic  cpu_rd_en,
    input  word_t cpu_wrt_data,
    input  addr_t accel_addr,
    input  logic  accel_wrt_en,
    input  logic  accel_rd_en,
    input  word_t accel_wrt_data,
    input  word_t mem_rd_data,
    input  line_t mem_line_data,
    output addr_t mem_addr,
    output logic  mem_wrt_en,
    output word_t mem_wrt_data,
    output logic  mem_rd_en,
    output logic  mem_line_rd_en,
    output word_t cpu_rd_data,
    output logic  accel_wrt_done,
    output logic  accel_rd_valid,
    output line_t accel_rd_data
);

    localparam addr_t DM_MASK = addr_t'(DM_LINES * 64 - 1);   // folds into the memory

    logic  cpu_req, accel_req, accel_pulse;
    logic  grant_ld, grant_cpu, grant_accel;
    addr_t sel_addr;

    assign cpu_req     = cpu_rd_en || (cpu_wrt_en && !host_claim);  // host stores stay out
    assign accel_req   = accel_rd_en || accel_wrt_en;
    assign accel_pulse = accel_wrt_done || accel_rd_valid;

    assign grant_ld    = ld_wrt_en;
    assign grant_cpu   = !grant_ld && cpu_req;
    assign grant_accel = !grant_ld && !cpu_req && accel_req && !accel_pulse;

    ////////////////////////////////////////////////////////////
    // memory port mux

    always_comb begin
        sel_addr       = accel_addr;
        mem_wrt_data   = accel_wrt_data;
        mem_wrt_en     = grant_accel && accel_wrt_en;
        mem_rd_en      = 1'b0;
        mem_line_rd_en = grant_accel && accel_rd_en && !accel_wrt_en;
        if (grant_ld) begin
            sel_addr       = ld_addr;
            mem_wrt_data   = ld_wrt_data;
            mem_wrt_en     = 1'b1;
            mem_line_rd_en = 1'b0;
        end else if (grant_cpu) begin
            sel_addr       = cpu_addr;
            mem_wrt_data   = cpu_wrt_data;
            mem_wrt_en     = cpu_wrt_en && !host_claim;
            mem_rd_en      = cpu_rd_en;
            mem_line_rd_en = 1'b0;
        end
    end

    assign mem_addr = sel_addr & DM_MASK;

    // accelerator pulse one cycle after its grant, with the read line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wrt_done <= 1'b0;
            accel_rd_valid <= 1'b0;
        end else begin
            accel_wrt_done <= grant_accel && accel_wrt_en;
            accel_rd_valid <= grant_accel && accel_rd_en && !accel_wrt_en;
        end
    end

    assign cpu_rd_data   = mem_rd_data;      // registered in the memory
    assign accel_rd_data = mem_line_data;

    // accelerator keeps its request and address until the pulse
    a_accel_held: assert property (@(posedge clk) disable iff (!rst_n)
        (accel_req && !accel_pulse) |=> (accel_req && $stable(accel_addr)));

endmodule

// ==== project.f ====
common/cpu_mem_pkg.sv
host_loader/host_loader.sv
memory/mem_arbiter.sv
memory/data_mem.sv
verilog/instr_mem.sv
verilog/cpu_mem_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== verif/tb_checker.sv ====
// testbench checker for the cpu memory subsystem
// reference data and instruction memories, compares the DUT ports against them
module tb_checker import cpu_mem_pkg::*; #(
    parameter int unsigned IM_BLOCKS = 48,
    parameter int unsigned DM_LINES  = 512
) (
    input logic       clk,
    input logic       rst_n,
    input host_op_t   host_op,
    input host_addr_t host_addr,
    input word_t      host_wrt_data,
    input logic       host_tx_done,
    input addr_t      cpu_addr,
    input logic       cpu_wrt_en,
    input logic       cpu_rd_en,
    input word_t      cpu_wrt_data,
    input word_t      cpu_rd_data,
    input logic       cpu_stall,
    input addr_t      accel_addr,
    input word_t      accel_wrt_data,
    input logic       accel_wrt_done,
    input logic       accel_rd_valid,
    input line_t      accel_rd_data,
    input addr_t      fetch_addr,
    input word_t      fetch_instr
);

    localparam int unsigned IM_LOADED   = IM_BLOCKS * WORDS_PER_BLOCK;
    localparam int unsigned BOOT_BLOCKS = DM_BLOCKS + IM_BLOCKS;

    word_t ref_dm [DM_LINES * 16];
    word_t ref_im [IM_LOADED];
    string cur_test = "none";
    int    err_count = 0, check_count = 0, tests_done = 0;
    int    test_errs = 0, test_checks = 0, boot_blocks = 0;
    logic  boot_done = 1'b0, rd_pending = 1'b0, fetch_pending = 1'b0;
    logic  prev_busy = 1'b0, prev_pulse = 1'b0;
    word_t rd_expect, fetch_expect;

    function automatic word_t rule_word(input addr_t a);
        return {a, 16'h5A00 + {8'h00, a[7:0]}};
    endfunction

    // byte address to word slot, folded like the 32 KB data memory
    function automatic int unsigned dm_slot(input addr_t a);
        return (int'(a) % (DM_LINES * 64)) / 4;
    endfunction

    initial begin
        addr_t a;
        for (int b = 0; b < DM_BLOCKS; b++) begin
            for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                a = DM_BLOCK_BASE[b] + addr_t'(4 * w);
                ref_dm[dm_slot(a)] = rule_word(a);
            end
        end
        for (int k = 0; k < IM_LOADED; k++) begin
            ref_im[k] = ~rule_word(addr_t'(4 * k));    // instruction blocks are inverted
        end
    end

    task automatic check_value(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        check_count++;
        test_checks++;
        if (act_v !== exp_v) begin
            err_count++;
            test_errs++;
            $display("FAILED %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
        end
    endtask

    task automatic report_error(input string msg);
        err_count++;
        test_errs++;
        $display("ERROR %s: %s", cur_test, msg);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic end_test();
        tests_done++;
        $display("%-14s %0d checks, %0d errors", cur_test, test_checks, test_errs);
    endtask

    task automatic close_report();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_done, check_count, err_count);
    endtask

    ////////////////////////////////////////////////////////////
    // per cycle comparison, all values from the cycle just ended

    always @(posedge clk) begin
        host_addr_t exp_addr;
        addr_t      line_base;
        logic       pulse;
        pulse = accel_wrt_done || accel_rd_valid;
        if (!rst_n) begin
            rd_pending    = 1'b0;
            fetch_pending = 1'b0;
        end else begin
            if (rd_pending) check_value("cpu read data", rd_expect, cpu_rd_data);
            if (fetch_pending) check_value("fetch instr", fetch_expect, fetch_instr);
            rd_pending    = 1'b0;
            fetch_pending = 1'b0;

            // accelerator side, before this cycle's cpu traffic
            if (pulse && prev_busy) report_error("accelerator served while the CPU port was busy");
            if (pulse && prev_pulse) report_error("accelerator pulse lasted more than one cycle");
            if (accel_rd_valid) begin
                line_base = {accel_addr[15:6], 6'h00};
                for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                    check_value("accel line word", ref_dm[dm_slot(line_base + addr_t'(4 * w))],
                                accel_rd_data[32*w +: 32]);
                end
            end
            if (accel_wrt_done) ref_dm[dm_slot(accel_addr)] = accel_wrt_data;

            if (boot_done) begin
                if (host_op == HOST_READ) report_error("host read request after the boot");
                if (fetch_addr[15:2] < IM_LOADED) begin
                    fetch_expect  = ref_im[fetch_addr[15:2]];
                    fetch_pending = 1'b1;
                end
                if (cpu_rd_en && !cpu_stall) begin
                    rd_expect  = ref_dm[dm_slot(cpu_addr)];
                    rd_pending = 1'b1;
                end
                if (cpu_wrt_en && cpu_addr >= HOST_BASE) begin   // memory stays untouched
                    check_value("forward host op", HOST_WRITE, host_op);
                    check_value("forward host addr", host_addr_t'(cpu_addr), host_addr);
                    check_value("forward host data", cpu_wrt_data, host_wrt_data);
                    check_value("forward cpu_stall", !host_tx_done, cpu_stall);
                end else if (cpu_wrt_en && !cpu_stall) begin
                    ref_dm[dm_slot(cpu_addr)] = cpu_wrt_data;
                end
            end else if (!cpu_stall) begin
                report_error("cpu_stall dropped before the boot finished");
            end

            // boot request order, data table first then flagged instruction blocks
            if (host_op == HOST_READ && host_tx_done && !boot_done) begin
                if (boot_blocks < DM_BLOCKS) begin
                    exp_addr = host_addr_t'(DM_BLOCK_BASE[boot_blocks]);
                end else begin
                    exp_addr = host_addr_t'((boot_blocks - DM_BLOCKS) * BLOCK_BYTES);
                    exp_addr[IM_HOST_FLAG_BIT] = 1'b1;
                end
                check_value("boot block addr", exp_addr, host_addr);
                boot_blocks++;
                boot_done = (boot_blocks == BOOT_BLOCKS);
            end
            prev_busy  = cpu_rd_en || (cpu_wrt_en && cpu_addr < HOST_BASE);
            prev_pulse = pulse;
        end
    end

endmodule

// ==== verif/tb_top.sv ====
// testbench top for the cpu memory subsystem
// clock, reset, host responder, cpu / fetch / accelerator stimulus and run limit
module tb_top import cpu_mem_pkg::*; ();

    localparam int unsigned IM_BLOCKS   = 48;
    localparam int unsigned DM_LINES    = 512;
    localparam int unsigned IM_WORDS    = 768;
    localparam int unsigned RUN_OPS     = 400;
    localparam int unsigned CYCLE_LIMIT = 2 * ((DM_BLOCKS + IM_BLOCKS) * 21 + RUN_OPS * 8);
    localparam int unsigned N_FETCH     = 100;
    localparam int unsigned N_CPU       = 120;
    localparam int unsigned N_FWD       = 16;
    localparam int unsigned N_ACCEL     = 16;
    localparam int unsigned N_TRAFFIC   = 30;

    logic       clk, rst_n, host_ready, host_rd_valid, host_tx_done;
    word_t      host_rd_data, cpu_wrt_data, accel_wrt_data;
    addr_t      cpu_addr, accel_addr, fetch_addr;
    logic       cpu_wrt_en, cpu_rd_en, accel_wrt_en, accel_rd_en;
    host_op_t   host_op;
    host_addr_t host_addr;
    word_t      host_wrt_data, cpu_rd_data, fetch_instr;
    logic       cpu_stall, accel_wrt_done, accel_rd_valid;
    line_t      accel_rd_data;
    int unsigned cycles = 0;
    int unsigned seed_val;

    cpu_mem_top #(.IM_BLOCKS(IM_BLOCKS), .DM_LINES(DM_LINES), .IM_WORDS(IM_WORDS)) UUT (
        .clk(clk), .rst_n(rst_n), .host_ready(host_ready), .host_rd_valid(host_rd_valid),
        .host_tx_done(host_tx_done), .host_rd_data(host_rd_data), .cpu_addr(cpu_addr),
        .cpu_wrt_en(cpu_wrt_en), .cpu_rd_en(cpu_rd_en), .cpu_wrt_data(cpu_wrt_data),
        .accel_addr(accel_addr), .accel_wrt_en(accel_wrt_en), .accel_rd_en(accel_rd_en),
        .accel_wrt_data(accel_wrt_data), .fetch_addr(fetch_addr), .host_op(host_op),
        .host_addr(host_addr), .host_wrt_data(host_wrt_data), .cpu_rd_data(cpu_rd_data),
        .cpu_stall(cpu_stall), .accel_wrt_done(accel_wrt_done),
        .accel_rd_valid(accel_rd_valid), .accel_rd_data(accel_rd_data),
        .fetch_instr(fetch_instr)
    );

    tb_checker #(.IM_BLOCKS(IM_BLOCKS), .DM_LINES(DM_LINES)) u_check (
        .clk(clk), .rst_n(rst_n), .host_op(host_op), .host_addr(host_addr),
        .host_wrt_data(host_wrt_data), .host_tx_done(host_tx_done), .cpu_addr(cpu_addr),
        .cpu_wrt_en(cpu_wrt_en), .cpu_rd_en(cpu_rd_en), .cpu_wrt_data(cpu_wrt_data),
        .cpu_rd_data(cpu_rd_data), .cpu_stall(cpu_stall), .accel_addr(accel_addr),
        .accel_wrt_data(accel_wrt_data), .accel_wrt_done(accel_wrt_done),
        .accel_rd_valid(accel_rd_valid), .accel_rd_data(accel_rd_data),
        .fetch_addr(fetch_addr), .fetch_instr(fetch_instr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run hung: no finish after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // host word for block base plus word index, flag bit selects the inverse
    function automatic word_t block_word(input host_addr_t base, input int unsigned i);
        addr_t a;
        word_t w;
        a = base[15:0] + addr_t'(4 * i);
        w = {a, 16'h5A00 + {8'h00, a[7:0]}};
        return base[IM_HOST_FLAG_BIT] ? ~w : w;
    endfunction

    function automatic addr_t known_addr(input int unsigned blocks);
        return DM_BLOCK_BASE[$urandom % blocks] + addr_t'(4 * ($urandom % WORDS_PER_BLOCK));
    endfunction

    ////////////////////////////////////////////////////////////
    // host responder

    task automatic serve_host_read();
        host_addr_t base;
        base = host_addr;
        repeat ($urandom % 5) @(posedge clk);
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            host_rd_data  <= block_word(base, i);
            host_rd_valid <= (i == 0);
            host_tx_done  <= (i == WORDS_PER_BLOCK - 1);
            @(posedge clk);
        end
        host_rd_valid <= 1'b0;
        host_tx_done  <= 1'b0;
    endtask

    task automatic serve_host_write();
        repeat ($urandom % 5) @(posedge clk);   // 1 to 5 cycles with the one below
        host_tx_done <= 1'b1;
        @(posedge clk);
        host_tx_done <= 1'b0;
    endtask

    initial begin
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            if (host_op == HOST_READ) serve_host_read();
            else if (host_op == HOST_WRITE) serve_host_write();
        end
    end

    ////////////////////////////////////////////////////////////
    // cpu and accelerator ports

    task automatic cpu_read(input addr_t a);
        cpu_addr   <= a;
        cpu_rd_en  <= 1'b1;
        cpu_wrt_en <= 1'b0;
        @(posedge clk);
        while (cpu_stall) @(posedge clk);
        cpu_rd_en <= 1'b0;
    endtask

    task automatic cpu_write(input addr_t a, input word_t d);
        cpu_addr     <= a;
        cpu_wrt_data <= d;
        cpu_wrt_en   <= 1'b1;
        cpu_rd_en    <= 1'b0;
        @(posedge clk);
        while (cpu_stall) @(posedge clk);     // port held until the store is taken
        cpu_wrt_en <= 1'b0;
    endtask

    task automatic accel_read(input addr_t a);
        accel_addr  <= a;
        accel_rd_en <= 1'b1;
        @(posedge clk);
        while (!accel_rd_valid) @(posedge clk);
        accel_rd_en <= 1'b0;
    endtask

    task automatic accel_write(input addr_t a, input word_t d);
        accel_addr     <= a;
        accel_wrt_data <= d;
        accel_wrt_en   <= 1'b1;
        @(posedge clk);
        while (!accel_wrt_done) @(posedge clk);
        accel_wrt_en <= 1'b0;
    endtask

    task automatic next_test(input string name);
        repeat (2) @(posedge clk);
        @(negedge clk);
        u_check.end_test();
        u_check.start_test(name);
        @(posedge clk);
    endtask

    initial begin
        addr_t a;
        seed_val       = $urandom(32'h89e1c481);
        rst_n          = 1'b0;
        host_ready     = 1'b0;
        host_rd_valid  = 1'b0;
        host_tx_done   = 1'b0;
        host_rd_data   = '0;
        cpu_addr       = '0;
        cpu_wrt_en     = 1'b0;
        cpu_rd_en      = 1'b0;
        cpu_wrt_data   = '0;
        accel_addr     = '0;
        accel_wrt_en   = 1'b0;
        accel_rd_en    = 1'b0;
        accel_wrt_data = '0;
        fetch_addr     = '0;
        u_check.start_test("boot_order");
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        host_ready <= 1'b1;
        @(posedge clk);
        while (cpu_stall) @(posedge clk);      // boot ends at the first stall release

        next_test("instr_fetch");
        repeat (N_FETCH) begin
            fetch_addr <= addr_t'(4 * ($urandom % (IM_BLOCKS * WORDS_PER_BLOCK)));
            @(posedge clk);
        end

        next_test("cpu_data");
        repeat (N_CPU) begin
            a = known_addr(DM_BLOCKS);
            if ($urandom % 2) cpu_write(a, $urandom);
            cpu_read(a);
        end

        next_test("host_forward");
        repeat (N_FWD) begin
            a = known_addr(DM_BLOCKS - 1);         // blocks at 0x1000 and up
            cpu_write(a | 16'h8000, $urandom);
            cpu_read(a);                           // low alias keeps its old value
        end

        next_test("accel_access");
        repeat (N_ACCEL) begin
            accel_read(known_addr(DM_BLOCKS));
            a = known_addr(DM_BLOCKS);
            accel_write(a, $urandom);
            cpu_read(a);
        end
        // line read held off by back to back cpu reads
        accel_addr  <= known_addr(DM_BLOCKS);
        accel_rd_en <= 1'b1;
        repeat (N_TRAFFIC) cpu_read(known_addr(DM_BLOCKS));
        while (!accel_rd_valid) @(posedge clk);
        accel_rd_en <= 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        u_check.end_test();
        u_check.close_report();
        if (u_check.err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/cpu_mem_top.sv ====
// cpu memory subsystem top level
// boot loader, data memory arbiter, data memory and instruction memory
module cpu_mem_top import cpu_mem_pkg::*; #(
    parameter int unsigned IM_BLOCKS = 48,
    parameter int unsigned DM_LINES  = 512,
    parameter int unsigned IM_WORDS  = 768
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       host_ready,
    input  logic       host_rd_valid,
    input  logic       host_tx_done,
    input  word_t      host_rd_data,
    input  addr_t      cpu_addr,
    input  logic       cpu_wrt_en,
    input  logic       cpu_rd_en,
    input  word_t      cpu_wrt_data,
    input  addr_t      accel_addr,
    input  logic       accel_wrt_en,
    input  logic       accel_rd_en,
    input  word_t      accel_wrt_data,
    input  addr_t      fetch_addr,
    output host_op_t   host_op,
    output host_addr_t host_addr,
    output word_t      host_wrt_data,
    output word_t      cpu_rd_data,
    output logic       cpu_stall,
    output logic       accel_wrt_done,
    output logic       accel_rd_valid,
    output line_t      accel_rd_data,
    output word_t      fetch_instr
);

    ////////////////////////////////////////////////////////////
    // internal nets

    logic  host_claim;
    logic  ld_wrt_en, im_wrt_en;
    addr_t ld_addr, im_wrt_addr;
    word_t ld_wrt_data, im_wrt_data;
    addr_t mem_addr;                  // arbiter -> data memory
    logic  mem_wrt_en, mem_rd_en, mem_line_rd_en;
    word_t mem_wrt_data, mem_rd_data;
    line_t mem_line_data;

    host_loader #(.IM_BLOCKS(IM_BLOCKS)) u_loader (
        .clk(clk), .rst_n(rst_n), .host_ready(host_ready), .host_rd_valid(host_rd_valid),
        .host_tx_done(host_tx_done), .host_rd_data(host_rd_data), .cpu_addr(cpu_addr),
        .cpu_wrt_en(cpu_wrt_en), .cpu_wrt_data(cpu_wrt_data), .host_op(host_op),
        .host_addr(host_addr), .host_wrt_data(host_wrt_data), .cpu_stall(cpu_stall),
        .host_claim(host_claim), .ld_wrt_en(ld_wrt_en), .ld_addr(ld_addr),
        .ld_wrt_data(ld_wrt_data), .im_wrt_en(im_wrt_en), .im_wrt_addr(im_wrt_addr),
        .im_wrt_data(im_wrt_data)
    );

    mem_arbiter #(.DM_LINES(DM_LINES)) u_arbiter (
        .clk(clk), .rst_n(rst_n), .ld_wrt_en(ld_wrt_en), .ld_addr(ld_addr),
        .ld_wrt_data(ld_wrt_data), .host_claim(host_claim), .cpu_addr(cpu_addr),
        .cpu_wrt_en(cpu_wrt_en), .cpu_rd_en(cpu_rd_en), .cpu_wrt_data(cpu_wrt_data),
        .accel_addr(accel_addr), .accel_wrt_en(accel_wrt_en), .accel_rd_en(accel_rd_en),
        .accel_wrt_data(accel_wrt_data), .mem_rd_data(mem_rd_data),
        .mem_line_data(mem_line_data), .mem_addr(mem_addr), .mem_wrt_en(mem_wrt_en),
        .mem_wrt_data(mem_wrt_data), .mem_rd_en(mem_rd_en), .mem_line_rd_en(mem_line_rd_en),
        .cpu_rd_data(cpu_rd_data), .accel_wrt_done(accel_wrt_done),
        .accel_rd_valid(accel_rd_valid), .accel_rd_data(accel_rd_data)
    );

    data_mem #(.DM_LINES(DM_LINES)) u_dmem (
        .clk(clk), .rst_n(rst_n), .mem_addr(mem_addr), .mem_wrt_en(mem_wrt_en),
        .mem_wrt_data(mem_wrt_data), .mem_rd_en(mem_rd_en), .mem_line_rd_en(mem_line_rd_en),
        .mem_rd_data(mem_rd_data), .mem_line_data(mem_line_data)
    );

    instr_mem #(.IM_WORDS(IM_WORDS)) u_imem (
        .clk(clk), .rst_n(rst_n), .im_wrt_en(im_wrt_en), .im_wrt_addr(im_wrt_addr),
        .im_wrt_data(im_wrt_data), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr)
    );

endmodule

// ==== verilog/instr_mem.sv ====
// instruction memory
// single port, loader writes take it over the fetch
module instr_mem import cpu_mem_pkg::*; #(
    parameter int unsigned IM_WORDS = 768
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  im_wrt_en,
    input  addr_t im_wrt_addr,
    input  word_t im_wrt_data,
    input  addr_t fetch_addr,
    output word_t fetch_instr
);

    localparam int unsigned IM_AW = (IM_WORDS > 1) ? $clog2(IM_WORDS) : 1;

    word_t            mem [IM_WORDS];
    addr_t            port_addr;
    logic [IM_AW-1:0] word_idx;

    assign port_addr = im_wrt_en ? im_wrt_addr : fetch_addr;  // loader owns the port
    assign word_idx  = port_addr[IM_AW+1:2];

    always_ff @(posedge clk) begin
        if (im_wrt_en) begin
            mem[word_idx] <= im_wrt_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_instr <= '0;
        end else begin
            fetch_instr <= im_wrt_en ? im_wrt_data : mem[word_idx];  // write-first
        end
    end

    a_wrt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        im_wrt_en |-> (im_wrt_addr[15:2] < IM_WORDS));

endmodule
